/* pixel_pkg.sv */
package pixel_pkg;

	// merged HDR sample coming out of the exposure fusion stage
	localparam int sample_w = 12;

	// fixed point used by the tone curve, 1.0 is 1 << fp
	localparam int fp = 8;

	// key value a = 0.18 in the fp format
	localparam int key = 46;

	localparam int n_chan = 3;

	// RGB565 code widths
	localparam int red_w = 5;
	localparam int green_w = 6;
	localparam int blue_w = 5;

	// full scale codes per channel
	localparam int red_max = 31;
	localparam int green_max = 63;
	localparam int blue_max = 31;

	// adaptation level used until the first frame has been measured
	localparam int mean_reset = 256;

endpackage

/* mem_pkg.sv */
package mem_pkg;

	// one burst beat towards frame memory
	localparam int word_w = 128;

	// RGB565 pixels packed per beat
	localparam int pix_per_word = 8;

	localparam int addr_w = 25;

	// frame buffer region, in word addresses
	localparam logic [addr_w-1:0] def_base = 25'hE1000;
	localparam logic [addr_w-1:0] def_limit = 25'h12C000;

endpackage

/* luma_stats.sv */
`timescale 1ns/1ps

module luma_stats #(
	parameter int n_pixels = 307200
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           hdr_done,
	input  logic [pixel_pkg::sample_w-1:0] le_red,
	input  logic [pixel_pkg::sample_w-1:0] le_green,
	input  logic [pixel_pkg::sample_w-1:0] le_blue,
	input  logic                           frame_done,
	output logic                           pix_valid,
	output logic [pixel_pkg::sample_w-1:0] sample_r,
	output logic [pixel_pkg::sample_w-1:0] sample_g,
	output logic [pixel_pkg::sample_w-1:0] sample_b,
	output logic [pixel_pkg::sample_w-1:0] mean_r,
	output logic [pixel_pkg::sample_w-1:0] mean_g,
	output logic [pixel_pkg::sample_w-1:0] mean_b
);

	localparam int sw = pixel_pkg::sample_w;
	// wide enough for n_pixels full scale samples
	localparam int sum_w = sw + $clog2(n_pixels + 1);

	logic [sw-1:0]    le_in    [pixel_pkg::n_chan];
	logic [sum_w-1:0] sum      [pixel_pkg::n_chan];
	logic [sw-1:0]    mean_q   [pixel_pkg::n_chan];
	logic [sw-1:0]    new_mean [pixel_pkg::n_chan];

	assign le_in[0] = le_red;
	assign le_in[1] = le_green;
	assign le_in[2] = le_blue;

	// frame average, never below 1 so the lanes never divide by zero
	always_comb begin
		for (int c = 0; c < pixel_pkg::n_chan; c++) begin
			new_mean[c] = sw'(sum[c] / sum_w'(n_pixels));
			if (new_mean[c] == '0)
				new_mean[c] = sw'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
			for (int c = 0; c < pixel_pkg::n_chan; c++) begin
				sum[c] <= '0;
				mean_q[c] <= sw'(pixel_pkg::mean_reset);
			end
		end else begin
			pix_valid <= hdr_done;
			for (int c = 0; c < pixel_pkg::n_chan; c++) begin
				if (hdr_done) begin
					sum[c] <= sum[c] + sum_w'(le_in[c]);
				end else if (frame_done) begin
					sum[c] <= '0;
					mean_q[c] <= new_mean[c];
				end
			end
		end
	end

	// pixel and the adaptation level it is mapped with
	always_ff @(posedge clk) begin
		if (hdr_done) begin
			sample_r <= le_red;
			sample_g <= le_green;
			sample_b <= le_blue;
			mean_r <= mean_q[0];
			mean_g <= mean_q[1];
			mean_b <= mean_q[2];
		end
	end

endmodule

/* tone_lane.sv */
`timescale 1ns/1ps

module tone_lane #(
	parameter int out_w = 5,
	parameter int out_max = 31
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           pix_valid,
	input  logic [pixel_pkg::sample_w-1:0] sample,
	input  logic [pixel_pkg::sample_w-1:0] mean,
	output logic                           code_valid,
	output logic [out_w-1:0]               code
);

	// s = sample * key / mean peaks at 4095 * 46 with mean 1
	localparam int s_w = pixel_pkg::sample_w + $clog2(pixel_pkg::key + 1);
	localparam int d_w = s_w + 1;
	localparam int n_w = s_w + out_w;
	localparam int one = 1 << pixel_pkg::fp;

	logic [s_w-1:0] scaled;
	logic [s_w-1:0] s_next;
	logic [s_w-1:0] s_q;
	logic           s_valid;
	logic [n_w-1:0] num;
	logic [d_w-1:0] den;

	// stage 1, luminance scaled by the key over the channel mean
	assign scaled = s_w'(sample) * s_w'(pixel_pkg::key);
	assign s_next = scaled / s_w'(mean);

	// stage 2, Reinhard compression s / (1 + s) to full scale
	assign num = n_w'(s_q) * n_w'(out_max);
	assign den = d_w'(s_q) + d_w'(one);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_valid <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			s_valid <= pix_valid;
			code_valid <= s_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pix_valid)
			s_q <= s_next;
		if (s_valid)
			code <= out_w'(num / n_w'(den));
	end

endmodule

/* rgb565_packer.sv */
`timescale 1ns/1ps

module rgb565_packer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          code_valid,
	input  logic [pixel_pkg::red_w-1:0]   code_r,
	input  logic [pixel_pkg::green_w-1:0] code_g,
	input  logic [pixel_pkg::blue_w-1:0]  code_b,
	output logic                          word_valid,
	output logic [mem_pkg::word_w-1:0]    word_data
);

	localparam int pix_w = mem_pkg::word_w / mem_pkg::pix_per_word;
	localparam int slot_w = $clog2(mem_pkg::pix_per_word);
	localparam logic [slot_w-1:0] final_slot = slot_w'(mem_pkg::pix_per_word - 1);

	logic [slot_w-1:0]          slot;
	logic [pix_w-1:0]           pix;
	logic [mem_pkg::word_w-1:0] fill;
	logic [mem_pkg::word_w-1:0] fill_next;

	// low byte {red, green[5:3]}, high byte {green[2:0], blue}
	assign pix = {code_g[2:0], code_b, code_r, code_g[pixel_pkg::green_w-1:3]};

	always_comb begin
		fill_next = fill;
		fill_next[slot*pix_w +: pix_w] = pix;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= code_valid && (slot == final_slot);
			if (code_valid)
				slot <= slot + 1'b1;
		end
	end

	// completed word is copied out so the next one can start filling at once
	always_ff @(posedge clk) begin
		if (code_valid) begin
			fill <= fill_next;
			if (slot == final_slot)
				word_data <= fill_next;
		end
	end

endmodule

/* ram_writer.sv */
`timescale 1ns/1ps

module ram_writer #(
	parameter logic [mem_pkg::addr_w-1:0] base_addr = mem_pkg::def_base,
	parameter logic [mem_pkg::addr_w-1:0] limit_addr = mem_pkg::def_limit
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       word_valid,
	input  logic [mem_pkg::word_w-1:0] word_data,
	input  logic                       ram_busy,
	output logic                       wr_req,
	output logic [mem_pkg::word_w-1:0] wr_data,
	output logic [mem_pkg::addr_w-1:0] wr_address,
	output logic                       last_slot,
	output logic                       overrun
);

	logic pending;
	logic want;

	// a word is waiting, either arriving now or held from before
	assign want = word_valid || pending;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
			wr_req <= 1'b0;
			overrun <= 1'b0;
			wr_address <= base_addr;
		end else begin
			// busy is sampled here, so the request follows a free cycle
			wr_req <= want && !ram_busy;
			pending <= want && ram_busy;
			// new word replaces one that never reached memory
			overrun <= word_valid && pending;
			if (wr_req) begin
				if (wr_address == limit_addr)
					wr_address <= base_addr;
				else
					wr_address <= wr_address + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_valid)
			wr_data <= word_data;
	end

	assign last_slot = (wr_address == limit_addr);

endmodule

/* tone_map.sv */
`timescale 1ns/1ps

module tone_map #(
	parameter int n_pixels = 307200,
	parameter logic [mem_pkg::addr_w-1:0] base_addr = mem_pkg::def_base,
	parameter logic [mem_pkg::addr_w-1:0] limit_addr = mem_pkg::def_limit
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           hdr_done,
	input  logic [pixel_pkg::sample_w-1:0] le_red,
	input  logic [pixel_pkg::sample_w-1:0] le_green,
	input  logic [pixel_pkg::sample_w-1:0] le_blue,
	input  logic                           frame_done,
	input  logic                           ram_busy,
	output logic                           wr_req,
	output logic [mem_pkg::word_w-1:0]     wr_data,
	output logic [mem_pkg::addr_w-1:0]     wr_address,
	output logic                           last_slot,
	output logic                           overrun
);

	logic                             pix_valid;
	logic [pixel_pkg::sample_w-1:0]   sample [pixel_pkg::n_chan];
	logic [pixel_pkg::sample_w-1:0]   mean   [pixel_pkg::n_chan];
	logic [pixel_pkg::n_chan-1:0]     lane_valid;
	logic                             word_valid;
	logic [mem_pkg::word_w-1:0]       word_data;

	luma_stats #(
		.n_pixels(n_pixels)
	) luma_stats_i (
		.clk(clk),
		.rst_n(rst_n),
		.hdr_done(hdr_done),
		.le_red(le_red),
		.le_green(le_green),
		.le_blue(le_blue),
		.frame_done(frame_done),
		.pix_valid(pix_valid),
		.sample_r(sample[0]),
		.sample_g(sample[1]),
		.sample_b(sample[2]),
		.mean_r(mean[0]),
		.mean_g(mean[1]),
		.mean_b(mean[2])
	);

	for (genvar c = 0; c < pixel_pkg::n_chan; c++) begin : lane_g
		localparam int out_w = (c == 0) ? pixel_pkg::red_w :
			(c == 1) ? pixel_pkg::green_w : pixel_pkg::blue_w;
		localparam int out_max = (c == 0) ? pixel_pkg::red_max :
			(c == 1) ? pixel_pkg::green_max : pixel_pkg::blue_max;

		logic [out_w-1:0] code;

		tone_lane #(
			.out_w(out_w),
			.out_max(out_max)
		) tone_lane_i (
			.clk(clk),
			.rst_n(rst_n),
			.pix_valid(pix_valid),
			.sample(sample[c]),
			.mean(mean[c]),
			.code_valid(lane_valid[c]),
			.code(code)
		);
	end

	// lanes run in lockstep, so lane 0 stands for the whole pixel
	rgb565_packer rgb565_packer_i (
		.clk(clk),
		.rst_n(rst_n),
		.code_valid(lane_valid[0]),
		.code_r(lane_g[0].code),
		.code_g(lane_g[1].code),
		.code_b(lane_g[2].code),
		.word_valid(word_valid),
		.word_data(word_data)
	);

	ram_writer #(
		.base_addr(base_addr),
		.limit_addr(limit_addr)
	) ram_writer_i (
		.clk(clk),
		.rst_n(rst_n),
		.word_valid(word_valid),
		.word_data(word_data),
		.ram_busy(ram_busy),
		.wr_req(wr_req),
		.wr_data(wr_data),
		.wr_address(wr_address),
		.last_slot(last_slot),
		.overrun(overrun)
	);

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
	parameter int n_pixels = 8,
	parameter logic [mem_pkg::addr_w-1:0] base_addr = mem_pkg::def_base,
	parameter logic [mem_pkg::addr_w-1:0] limit_addr = mem_pkg::def_limit
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           hdr_done,
	input  logic [pixel_pkg::sample_w-1:0] le_red,
	input  logic [pixel_pkg::sample_w-1:0] le_green,
	input  logic [pixel_pkg::sample_w-1:0] le_blue,
	input  logic                           frame_done,
	input  logic                           ram_busy,
	input  logic                           wr_req,
	input  logic [mem_pkg::word_w-1:0]     wr_data,
	input  logic [mem_pkg::addr_w-1:0]     wr_address,
	input  logic                           last_slot,
	input  logic                           overrun,
	output int                             err_count,
	output int                             write_count,
	output int                             overrun_count,
	output logic                           idle
);

	// eighth hdr_done to word_valid at the writer
	localparam int lat = 4;

	int                         sum [pixel_pkg::n_chan];
	int                         mean [pixel_pkg::n_chan];
	int                         slot;
	logic [mem_pkg::word_w-1:0] fill;
	logic [mem_pkg::word_w-1:0] dly_word [lat];
	logic                       dly_valid [lat];
	logic [mem_pkg::word_w-1:0] held;
	logic                       pend;
	logic                       exp_req;
	logic                       exp_ovr;
	logic [mem_pkg::addr_w-1:0] exp_addr;
	logic [mem_pkg::word_w-1:0] expq [$];

	// Reinhard curve: s = x * key / mean, code = full * s / (1 + s)
	function automatic int curve(input int x, input int mean_v, input int full);
		int s;
		s = x * pixel_pkg::key / mean_v;
		return full * s / ((1 << pixel_pkg::fp) + s);
	endfunction

	function automatic logic [15:0] rgb565(input int r, input int g, input int b);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = {r[4:0], g[5:3]};
		hi = {g[2:0], b[4:0]};
		return {hi, lo};
	endfunction

	task automatic report(input string msg);
		err_count++;
		$display("Fail at time %0t: %s", $time, msg);
	endtask

	always @(posedge clk) begin : model
		logic                       wv;
		logic [mem_pkg::word_w-1:0] wv_word;
		logic [mem_pkg::word_w-1:0] head;
		if (!rst_n) begin
			err_count = 0;
			write_count = 0;
			overrun_count = 0;
			slot = 0;
			pend = 1'b0;
			exp_req = 1'b0;
			exp_ovr = 1'b0;
			exp_addr = base_addr;
			expq.delete();
			for (int c = 0; c < pixel_pkg::n_chan; c++) begin
				sum[c] = 0;
				mean[c] = pixel_pkg::mean_reset;
			end
			for (int i = 0; i < lat; i++)
				dly_valid[i] = 1'b0;
		end else begin
			// outputs left by the previous edge
			if (wr_req !== exp_req)
				report($sformatf("wr_req is %b, expected %b", wr_req, exp_req));
			if (overrun !== exp_ovr)
				report($sformatf("overrun is %b, expected %b", overrun, exp_ovr));
			if (last_slot !== (exp_addr == limit_addr))
				report($sformatf("last_slot is %b with model address %h", last_slot, exp_addr));
			if (overrun === 1'b1)
				overrun_count++;
			if (exp_req)
				expq.push_back(held);
			if (wr_req === 1'b1) begin
				write_count++;
				if (expq.size() == 0) begin
					report("wr_req with no word expected");
				end else begin
					head = expq.pop_front();
					if (wr_data !== head)
						report($sformatf("wr_data %h, expected %h", wr_data, head));
					if (wr_address !== exp_addr)
						report($sformatf("wr_address %h, expected %h", wr_address, exp_addr));
				end
			end
			if (exp_req)
				exp_addr = (exp_addr == limit_addr) ? base_addr : exp_addr + 25'd1;

			wv = dly_valid[lat-1];
			wv_word = dly_word[lat-1];
			for (int i = lat - 1; i > 0; i--) begin
				dly_valid[i] = dly_valid[i-1];
				dly_word[i] = dly_word[i-1];
			end
			dly_valid[0] = 1'b0;

			if (hdr_done) begin
				fill[slot*16 +: 16] = rgb565(curve(int'(le_red), mean[0], pixel_pkg::red_max),
					curve(int'(le_green), mean[1], pixel_pkg::green_max),
					curve(int'(le_blue), mean[2], pixel_pkg::blue_max));
				sum[0] += int'(le_red);
				sum[1] += int'(le_green);
				sum[2] += int'(le_blue);
				if (slot == mem_pkg::pix_per_word - 1) begin
					dly_valid[0] = 1'b1;
					dly_word[0] = fill;
					slot = 0;
				end else begin
					slot++;
				end
			end else if (frame_done) begin
				for (int c = 0; c < pixel_pkg::n_chan; c++) begin
					mean[c] = sum[c] / n_pixels;
					if (mean[c] == 0)
						mean[c] = 1;
					sum[c] = 0;
				end
			end

			// writer: a held word goes out once busy was seen low
			exp_ovr = wv && pend;
			if (wv)
				held = wv_word;
			exp_req = (wv || pend) && !ram_busy;
			pend = (wv || pend) && ram_busy;
		end
		idle = !pend && !exp_req && (expq.size() == 0);
		for (int i = 0; i < lat; i++)
			if (dly_valid[i])
				idle = 1'b0;
	end

endmodule

/* tb_tone_map.sv */
`timescale 1ns/1ps

module tb_tone_map;

	localparam int n_pixels = 8;
	localparam logic [mem_pkg::addr_w-1:0] base_addr = 25'h100;
	localparam logic [mem_pkg::addr_w-1:0] limit_addr = 25'h103;
	localparam int n_rows = 8;
	localparam int drain_limit = 200;

	// count pixels from r, g, b stepping by step; rnd takes samples and busy from the LFSR
	typedef struct {
		int test;
		int count;
		int r;
		int g;
		int b;
		int step;
		bit fend;
		int busy;
		bit rnd;
	} row_t;

	row_t rows [n_rows] = '{
		'{1, 8, 400, 1000, 1800, 300, 1'b1, 0, 1'b0},
		'{2, 8, 0, 0, 0, 0, 1'b1, 0, 1'b1},
		'{2, 8, 0, 0, 0, 0, 1'b1, 0, 1'b0},
		'{3, 8, 1, 2, 3, 1, 1'b1, 0, 1'b0},
		'{4, 8, 0, 0, 0, 0, 1'b1, 0, 1'b1},
		'{5, 7, 2000, 2000, 2000, 10, 1'b0, 0, 1'b0},
		'{5, 1, 2100, 2100, 2100, 0, 1'b1, 16, 1'b0},
		'{6, 16, 600, 700, 800, 50, 1'b1, 40, 1'b0}
	};
	string names [6] = '{"first frame", "mean adaptation", "packing order",
		"address wrap", "back-pressure", "overrun"};

	logic                           clk = 1'b0;
	logic                           rst_n;
	logic                           hdr_done;
	logic [pixel_pkg::sample_w-1:0] le_red;
	logic [pixel_pkg::sample_w-1:0] le_green;
	logic [pixel_pkg::sample_w-1:0] le_blue;
	logic                           frame_done;
	logic                           ram_busy;
	logic                           wr_req;
	logic [mem_pkg::word_w-1:0]     wr_data;
	logic [mem_pkg::addr_w-1:0]     wr_address;
	logic                           last_slot;
	logic                           overrun;
	int                             errors;
	int                             writes;
	int                             overruns;
	logic                           idle;
	logic [15:0]                    lfsr;
	int                             busy_left;
	int                             prev_err;
	int                             prev_wr;
	int                             prev_ovr;
	logic                           timed_out;

	always #20 clk = ~clk;

	tone_map #(
		.n_pixels(n_pixels),
		.base_addr(base_addr),
		.limit_addr(limit_addr)
	) tone_map_i (.*);

	tb_checker #(
		.n_pixels(n_pixels),
		.base_addr(base_addr),
		.limit_addr(limit_addr)
	) checker_i (
		.err_count(errors),
		.write_count(writes),
		.overrun_count(overruns),
		.*
	);

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic drive_cycle(input logic h, input logic f);
		hdr_done = h;
		frame_done = f;
		ram_busy = (busy_left > 0);
		if (busy_left > 0)
			busy_left--;
		@(posedge clk);
		#2;
	endtask

	// let the last words reach memory, then report the test
	task automatic finish_test(input int t);
		int n;
		n = 0;
		while (!idle && n < drain_limit) begin
			drive_cycle(1'b0, 1'b0);
			n++;
		end
		if (!idle) begin
			$display("timeout: test %0d never finished writing its words", t);
			timed_out = 1'b1;
		end else begin
			$display("test %0d %s: %0d words, %0d overruns, %0d errors", t, names[t-1],
				writes - prev_wr, overruns - prev_ovr, errors - prev_err);
			prev_wr = writes;
			prev_ovr = overruns;
			prev_err = errors;
		end
	endtask

	initial begin
		int cur;
		int v;
		rst_n = 1'b0;
		hdr_done = 1'b0;
		frame_done = 1'b0;
		ram_busy = 1'b0;
		le_red = '0;
		le_green = '0;
		le_blue = '0;
		lfsr = 16'd36254;
		busy_left = 0;
		prev_err = 0;
		prev_wr = 0;
		prev_ovr = 0;
		timed_out = 1'b0;
		cur = 0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < n_rows && !timed_out; i++) begin
			if (rows[i].test != cur) begin
				if (cur != 0)
					finish_test(cur);
				cur = rows[i].test;
			end
			busy_left = rows[i].busy;
			for (int k = 0; k < rows[i].count; k++) begin
				if (rows[i].rnd) begin
					draw(12, v);
					le_red = 12'(v);
					draw(12, v);
					le_green = 12'(v);
					draw(12, v);
					le_blue = 12'(v);
					draw(2, busy_left);
				end else begin
					le_red = 12'(rows[i].r + k * rows[i].step);
					le_green = 12'(rows[i].g + k * rows[i].step);
					le_blue = 12'(rows[i].b + k * rows[i].step);
				end
				drive_cycle(1'b1, 1'b0);
				if (rows[i].fend && k == rows[i].count - 1)
					drive_cycle(1'b0, 1'b1);
				drive_cycle(1'b0, 1'b0);
			end
		end
		if (!timed_out)
			finish_test(cur);
		$display("all tests: %0d words, %0d overruns, %0d errors", writes, overruns, errors);
		if (errors == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sources.f */
pixel_pkg.sv
mem_pkg.sv
luma_stats.sv
tone_lane.sv
rgb565_packer.sv
ram_writer.sv
tone_map.sv
tb_checker.sv
tb_tone_map.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the tone mapping testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_tone_map \
	-f sources.f -o sim_tone_map
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tone_map > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi

exit 0
